// ==== common/ppu_pkg.sv ====
package ppu_pkg;

    //////////////////////////////////////////////////////////////////////
    // scan geometry
    //////////////////////////////////////////////////////////////////////
    localparam int SCAN_W = 9;                                    // scan_x / scan_y width

    localparam logic [SCAN_W-1:0] LAST_VIS_LINE    = 9'd239;      // last rendered line
    localparam logic [SCAN_W-1:0] FIRST_FRAME_LINE = 9'd240;      // loaded on frame start
    localparam logic [SCAN_W-1:0] LOAD_LINE        = 9'd260;      // scroll latch line
    localparam logic [SCAN_W-1:0] PRE_LINE         = 9'd261;      // prefetches line 0
    localparam logic [SCAN_W-1:0] VIS_WIDTH        = 9'd256;      // pixels per line

    localparam int NT_ROWS = 30;                                  // tile rows per name table

    //////////////////////////////////////////////////////////////////////
    // memory address widths
    //////////////////////////////////////////////////////////////////////
    localparam int PT_AW   = 12;
    localparam int NT_AW   = 12;
    localparam int PLT_AW  = 5;
    localparam int VBUF_AW = 17;

    // name table byte, read as a tile index or as an attribute byte
    typedef union packed {
        logic [7:0]      tile;                                    // pattern index
        logic [3:0][1:0] quad;                                    // palette per {cy[1], cx[1]}
    } nt_word_t;

    // {attr[1:0], pattern[1:0]}
    typedef logic [3:0] bg_pix_t;

endpackage

// ==== common/scan_if.sv ====
interface scan_if;

    logic [ppu_pkg::SCAN_W-1:0] scan_x;       // pixel counter
    logic [ppu_pkg::SCAN_W-1:0] scan_y;       // line counter
    logic                       pix_cyc;      // rendered pixel slot, incl. pre line
    logic                       fetch_cyc;    // whole visible or pre line
    logic                       line_end;     // last cycle of a line
    logic                       load_strobe;  // end of the scroll latch line

    modport cnt (
        output scan_x,
        output scan_y,
        output pix_cyc,
        output fetch_cyc,
        output line_end,
        output load_strobe
    );

    modport user (
        input scan_x,
        input scan_y,
        input pix_cyc,
        input fetch_cyc,
        input line_end,
        input load_strobe
    );

endinterface

// ==== src/ppu_frame_ctrl.sv ====
module ppu_frame_ctrl (
    input  logic  i_clk,
    input  logic  i_rstn,
    input  logic  i_vblank,
    scan_if.user  s,
    output logic  o_frame_start,
    output logic  o_run,
    output logic  o_vbuf_page
);

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_RUN  = 1'b1;

    logic r_vblank;
    logic rr_vblank;
    logic r_state;
    logic r_page;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_vblank  <= 1'b0;
            rr_vblank <= 1'b0;
        end else begin
            r_vblank  <= i_vblank;   // two stage sync
            rr_vblank <= r_vblank;
        end
    end

    assign o_frame_start = r_vblank & ~rr_vblank;   // vblank rising edge

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_state <= ST_IDLE;
            r_page  <= 1'b0;
        end else if (o_frame_start) begin
            r_state <= ST_RUN;
            r_page  <= ~r_page;      // new frame goes to the other page
        end else if (s.line_end && (s.scan_y == ppu_pkg::LAST_VIS_LINE)) begin
            r_state <= ST_IDLE;      // last rendered line done
        end
    end

    assign o_run       = (r_state == ST_RUN);
    assign o_vbuf_page = r_page;

    // vblank must not come back before the frame has finished line 239
    a_no_restart: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_frame_start |-> (r_state == ST_IDLE))
        else $error("frame start while a frame is running");

endmodule

// ==== src/ppu_scan_counter.sv ====
module ppu_scan_counter #(
    parameter logic [ppu_pkg::SCAN_W-1:0] SCAN_X_MAX = 9'd271
) (
    input  logic i_clk,
    input  logic i_rstn,
    input  logic i_frame_start,
    input  logic i_run,
    scan_if.cnt  s
);

    logic [ppu_pkg::SCAN_W-1:0] r_scan_x;
    logic [ppu_pkg::SCAN_W-1:0] r_scan_y;
    logic                       c_line_end;
    logic                       c_render_line;

    assign c_line_end = (r_scan_x == SCAN_X_MAX);

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_scan_x <= '0;
            r_scan_y <= ppu_pkg::FIRST_FRAME_LINE;   // parks outside the fetch lines
        end else if (i_frame_start) begin
            r_scan_x <= '0;
            r_scan_y <= ppu_pkg::FIRST_FRAME_LINE;
        end else if (i_run) begin
            if (c_line_end) begin
                r_scan_x <= '0;
                if (r_scan_y == ppu_pkg::PRE_LINE) begin
                    r_scan_y <= '0;
                end else begin
                    r_scan_y <= r_scan_y + 9'd1;
                end
            end else begin
                r_scan_x <= r_scan_x + 9'd1;
            end
        end
    end

    // visible lines plus the pre line
    assign c_render_line = (r_scan_y <= ppu_pkg::LAST_VIS_LINE) ||
                           (r_scan_y == ppu_pkg::PRE_LINE);

    assign s.scan_x      = r_scan_x;
    assign s.scan_y      = r_scan_y;
    assign s.fetch_cyc   = c_render_line;
    assign s.pix_cyc     = c_render_line && (r_scan_x < ppu_pkg::VIS_WIDTH);
    assign s.line_end    = c_line_end;
    assign s.load_strobe = c_line_end && (r_scan_y == ppu_pkg::LOAD_LINE);

    // the counter must park once the last visible line is done
    a_park_after_frame: assert property (@(posedge i_clk) disable iff (!i_rstn)
        (i_run && c_line_end && (r_scan_y == ppu_pkg::LAST_VIS_LINE)) |=> !i_run)
        else $error("run still high after the last visible line");

endmodule

// ==== bg/ppu_bg_fetch.sv ====
module ppu_bg_fetch (
    input  logic                       i_clk,
    input  logic                       i_rstn,
    scan_if.user                       s,
    input  logic [1:0]                 i_nt_base,
    input  logic                       i_bg_pt_sel,
    input  logic [7:0]                 i_scroll_x,
    input  logic [7:0]                 i_scroll_y,
    input  ppu_pkg::nt_word_t          i_nt_rdata,
    output logic [ppu_pkg::NT_AW-1:0]  o_nt_addr,
    output logic [ppu_pkg::PT_AW-1:0]  o_pt_addr,
    output logic [2:0]                 o_tile_phase,
    output logic [1:0]                 o_quad_sel,
    output logic [2:0]                 o_fine_x
);

    logic [2:0] c_phase;
    logic       c_hreload;
    logic       c_vadv;
    logic       c_step_x;
    logic [4:0] r_cx;
    logic [4:0] r_cx_start;
    logic [2:0] r_fine_x;
    logic       r_base_h;
    logic       r_base_h_start;
    logic [4:0] r_cy;
    logic [2:0] r_fy;
    logic       r_base_v;
    logic [7:0] r_tile;

    assign c_phase  = s.scan_x[2:0];
    assign c_step_x = s.fetch_cyc && (c_phase == 3'd7);

    // next line's prefetch starts at x=256, so the position moves on after pixel 255
    assign c_hreload = s.fetch_cyc && (s.scan_x == ppu_pkg::VIS_WIDTH - 9'd1);
    assign c_vadv    = c_hreload && (s.scan_y <= ppu_pkg::LAST_VIS_LINE);

    //////////////////////////////////////////////////////////////////////
    // horizontal position
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_cx           <= '0;
            r_cx_start     <= '0;
            r_fine_x       <= '0;
            r_base_h       <= 1'b0;
            r_base_h_start <= 1'b0;
        end else if (s.load_strobe) begin
            r_cx           <= i_scroll_x[7:3];
            r_cx_start     <= i_scroll_x[7:3];
            r_fine_x       <= i_scroll_x[2:0];
            r_base_h       <= i_nt_base[0];
            r_base_h_start <= i_nt_base[0];
        end else if (c_hreload) begin
            r_cx     <= r_cx_start;      // back to the left edge
            r_base_h <= r_base_h_start;
        end else if (c_step_x) begin
            r_cx <= r_cx + 5'd1;
            if (r_cx == 5'd31) begin
                r_base_h <= ~r_base_h;   // crossed into the right table
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // vertical position
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_cy     <= '0;
            r_fy     <= '0;
            r_base_v <= 1'b0;
        end else if (s.load_strobe) begin
            r_cy     <= i_scroll_y[7:3];
            r_fy     <= i_scroll_y[2:0];
            r_base_v <= i_nt_base[1];
        end else if (c_vadv) begin
            r_fy <= r_fy + 3'd1;
            if (r_fy == 3'd7) begin
                if (r_cy == 5'(ppu_pkg::NT_ROWS - 1)) begin
                    r_cy     <= '0;
                    r_base_v <= ~r_base_v;   // wrap to the lower table
                end else begin
                    r_cy <= r_cy + 5'd1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (s.fetch_cyc && (c_phase == 3'd1)) begin
            r_tile <= i_nt_rdata.tile;   // name byte back from phase 0
        end
    end

    always_comb begin
        if (c_phase == 3'd1) begin
            o_nt_addr = {r_base_v, r_base_h, 4'b1111, r_cy[4:2], r_cx[4:2]};   // attr byte
        end else begin
            o_nt_addr = {r_base_v, r_base_h, r_cy, r_cx};
        end
    end

    assign o_pt_addr = {i_bg_pt_sel, r_tile, r_fy};   // valid in phase 2

    assign o_tile_phase = {c_step_x,
                           s.fetch_cyc && (c_phase == 3'd3),
                           s.fetch_cyc && (c_phase == 3'd2)};
    assign o_quad_sel   = {r_cy[1], r_cx[1]};
    assign o_fine_x     = r_fine_x;

endmodule

// ==== bg/ppu_bg_shifter.sv ====
module ppu_bg_shifter (
    input  logic              i_clk,
    input  logic              i_rstn,
    scan_if.user              s,
    input  logic [2:0]        i_tile_phase,
    input  logic [1:0]        i_quad_sel,
    input  logic [2:0]        i_fine_x,
    input  ppu_pkg::nt_word_t i_nt_rdata,
    input  logic [15:0]       i_pt_rdata,
    input  logic              i_bg_ena,
    input  logic              i_bg_clip,
    output ppu_pkg::bg_pix_t  o_bg_pix
);

    logic [1:0]       r_quad;     // staged palette number
    logic [15:0]      r_patt;     // staged {hi plane, lo plane}
    logic [3:0][15:0] r_shft;     // attr hi, attr lo, patt hi, patt lo
    logic [3:0][7:0]  c_load;
    logic [3:0]       c_idx;
    logic [3:0]       c_bit;

    always_ff @(posedge i_clk) begin
        if (i_tile_phase[0]) begin
            r_quad <= i_nt_rdata.quad[i_quad_sel];
        end
        if (i_tile_phase[1]) begin
            r_patt <= i_pt_rdata;
        end
    end

    assign c_load = {{8{r_quad[1]}}, {8{r_quad[0]}}, r_patt[15:8], r_patt[7:0]};

    //////////////////////////////////////////////////////////////////////
    // shift every fetch cycle, new tile enters the low byte at phase 7
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_shft <= '0;
        end else if (s.fetch_cyc) begin
            for (int i = 0; i < 4; i++) begin
                if (i_tile_phase[2]) begin
                    r_shft[i] <= {r_shft[i][14:7], c_load[i]};
                end else begin
                    r_shft[i] <= {r_shft[i][14:0], 1'b0};
                end
            end
        end
    end

    assign c_idx = 4'd15 - {1'b0, i_fine_x};   // fine x picks the tap

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            c_bit[i] = r_shft[i][c_idx];
        end
    end

    assign o_bg_pix = (!i_bg_ena || (!i_bg_clip && (s.scan_x < 9'd8))) ? '0 : c_bit;

endmodule

// ==== src/ppu_vbuf_writer.sv ====
module ppu_vbuf_writer (
    input  logic                         i_clk,
    input  logic                         i_rstn,
    scan_if.user                         s,
    input  ppu_pkg::bg_pix_t             i_bg_pix,
    input  logic                         i_vbuf_page,
    input  logic [7:0]                   i_plt_rdata,
    output logic [ppu_pkg::PLT_AW-1:0]   o_plt_addr,
    output logic [ppu_pkg::VBUF_AW-1:0]  o_vbuf_addr,
    output logic                         o_vbuf_we,
    output logic [7:0]                   o_vbuf_wdata
);

    logic       r_we;
    logic [7:0] r_x;
    logic [7:0] r_y;

    assign o_plt_addr = {1'b0, i_bg_pix};   // bg half of the palette

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            r_we <= 1'b0;
        end else begin
            r_we <= s.pix_cyc && (s.scan_y <= ppu_pkg::LAST_VIS_LINE);   // pre line not stored
        end
    end

    always_ff @(posedge i_clk) begin
        r_x <= s.scan_x[7:0];   // aligned with palette read data
        r_y <= s.scan_y[7:0];
    end

    assign o_vbuf_we    = r_we;
    assign o_vbuf_addr  = {i_vbuf_page, r_y, r_x};
    assign o_vbuf_wdata = i_plt_rdata;

    // a write lands while the counter is still on its own visible line
    a_no_blank_write: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_vbuf_we |-> ((s.scan_y <= ppu_pkg::LAST_VIS_LINE) &&
                       (o_vbuf_addr[15:8] == s.scan_y[7:0])))
        else $error("video buffer write outside its visible line");

endmodule

// ==== src/ppu_bg_render.sv ====
module ppu_bg_render #(
    parameter logic [ppu_pkg::SCAN_W-1:0] SCAN_X_MAX = 9'd271
) (
    input  logic                         i_clk,
    input  logic                         i_rstn,
    input  logic [5:0]                   i_ppuctrl,
    input  logic [7:0]                   i_ppumask,
    input  logic [7:0]                   i_scroll_x,
    input  logic [7:0]                   i_scroll_y,
    input  logic                         i_vblank,
    output logic [ppu_pkg::PT_AW-1:0]    o_pt_addr,
    input  logic [15:0]                  i_pt_rdata,
    output logic [ppu_pkg::NT_AW-1:0]    o_nt_addr,
    input  logic [7:0]                   i_nt_rdata,
    output logic [ppu_pkg::PLT_AW-1:0]   o_plt_addr,
    input  logic [7:0]                   i_plt_rdata,
    output logic [ppu_pkg::VBUF_AW-1:0]  o_vbuf_addr,
    output logic                         o_vbuf_we,
    output logic [7:0]                   o_vbuf_wdata
);

    logic             frame_start;
    logic             run;
    logic             vbuf_page;
    logic [2:0]       tile_phase;    // {load, pattern latch, attr latch}
    logic [1:0]       quad_sel;
    logic [2:0]       fine_x;
    ppu_pkg::bg_pix_t bg_pix;

    scan_if u_scan ();

    ppu_frame_ctrl u_frame_ctrl (
        .i_clk         (i_clk),
        .i_rstn        (i_rstn),
        .i_vblank      (i_vblank),
        .s             (u_scan),
        .o_frame_start (frame_start),
        .o_run         (run),
        .o_vbuf_page   (vbuf_page)
    );

    ppu_scan_counter #(
        .SCAN_X_MAX (SCAN_X_MAX)
    ) u_scan_counter (
        .i_clk         (i_clk),
        .i_rstn        (i_rstn),
        .i_frame_start (frame_start),
        .i_run         (run),
        .s             (u_scan)
    );

    ppu_bg_fetch u_bg_fetch (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .s            (u_scan),
        .i_nt_base    (i_ppuctrl[1:0]),     // ctrl base select
        .i_bg_pt_sel  (i_ppuctrl[4]),       // bg pattern half
        .i_scroll_x   (i_scroll_x),
        .i_scroll_y   (i_scroll_y),
        .i_nt_rdata   (i_nt_rdata),
        .o_nt_addr    (o_nt_addr),
        .o_pt_addr    (o_pt_addr),
        .o_tile_phase (tile_phase),
        .o_quad_sel   (quad_sel),
        .o_fine_x     (fine_x)
    );

    ppu_bg_shifter u_bg_shifter (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .s            (u_scan),
        .i_tile_phase (tile_phase),
        .i_quad_sel   (quad_sel),
        .i_fine_x     (fine_x),
        .i_nt_rdata   (i_nt_rdata),
        .i_pt_rdata   (i_pt_rdata),
        .i_bg_ena     (i_ppumask[3]),       // mask bg enable
        .i_bg_clip    (i_ppumask[1]),       // show bg in left 8 px
        .o_bg_pix     (bg_pix)
    );

    ppu_vbuf_writer u_vbuf_writer (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .s            (u_scan),
        .i_bg_pix     (bg_pix),
        .i_vbuf_page  (vbuf_page),
        .i_plt_rdata  (i_plt_rdata),
        .o_plt_addr   (o_plt_addr),
        .o_vbuf_addr  (o_vbuf_addr),
        .o_vbuf_we    (o_vbuf_we),
        .o_vbuf_wdata (o_vbuf_wdata)
    );

endmodule

// ==== sim/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic o_clk,
    output logic o_rstn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk  = 1'b0;
        o_rstn = 1'b0;
        repeat (10) @(posedge o_clk);
        o_rstn <= 1'b1;
    end

    always #2 o_clk = ~o_clk;   // 4 ns period

endmodule

// ==== sim/ppu_bg_checker.sv ====
module ppu_bg_checker (
    input logic        i_clk,
    input logic        i_rstn,
    input logic        i_vbuf_we,
    input logic [16:0] i_vbuf_addr,
    input logic [7:0]  i_vbuf_wdata,
    input logic [5:0]  i_ppuctrl,
    input logic [7:0]  i_ppumask,
    input logic [7:0]  i_scroll_x,
    input logic [7:0]  i_scroll_y
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_PIX = 61440;   // 256 x 240

    string test_name;
    int    test_errs;
    int    frame_writes;
    int    tests_run;
    int    tests_failed;
    bit    seen [0:65535];
    bit    frame_open;
    bit    page_valid;
    bit    prev_valid;
    logic  page_cur;
    logic  page_prev;

    //////////////////////////////////////////////////////////////////////
    // memory contents shared with the models in the testbench top
    //////////////////////////////////////////////////////////////////////
    function automatic logic [7:0] nt_hash(input logic [11:0] a);
        logic [31:0] h;
        h = {20'd0, a} * 32'h9e3779b1;
        return h[23:16] ^ h[7:0];
    endfunction

    function automatic logic [15:0] pt_hash(input logic [11:0] a);
        logic [31:0] h;
        h = ({20'd0, a} + 32'h2f1) * 32'h85ebca6b;
        return h[31:16] ^ h[15:0];
    endfunction

    function automatic logic [7:0] plt_byte(input logic [4:0] a);
        logic [7:0] v;
        v = {3'd0, a} * 8'd7 + 8'd3;
        return v;
    endfunction

    // expected buffer byte for screen pixel (x, y)
    function automatic logic [7:0] ref_pixel(input int x, input int y,
                                             input logic [5:0] ctrl, input logic [7:0] mask,
                                             input logic [7:0] sx, input logic [7:0] sy);
        int         wx;
        int         wy;
        int         fx;
        logic       bh;
        logic       bv;
        logic [4:0] cx;
        logic [4:0] cy;
        logic [2:0] fy;
        logic [7:0] tile;
        logic [7:0] attr;
        logic [15:0] patt;
        logic [1:0] pal;
        logic [3:0] pix;
        wx = (x + int'(sx) + (ctrl[0] ? 256 : 0)) % 512;   // two tables side by side
        wy = y + int'(sy);
        bh = (wx >= 256);
        bv = ctrl[1];
        if (wy >= 240) begin
            wy = wy - 240;                                 // 30 rows, then next table
            bv = ~bv;
        end
        cx   = 5'((wx / 8) % 32);
        fx   = wx % 8;
        cy   = 5'(wy / 8);
        fy   = 3'(wy % 8);
        tile = nt_hash({bv, bh, cy, cx});
        attr = nt_hash({bv, bh, 4'hf, cy[4:2], cx[4:2]});
        pal  = 2'(attr >> (2 * int'({cy[1], cx[1]})));
        patt = pt_hash({ctrl[4], tile, fy});
        pix  = {pal, patt[15 - fx], patt[7 - fx]};
        if (!mask[3] || (!mask[1] && x < 8)) begin
            pix = 4'd0;
        end
        return plt_byte({1'b0, pix});
    endfunction

    task automatic note_error(input string msg);
        if (test_errs < 8) begin
            $display("%s", msg);
        end
        test_errs++;
    endtask

    task automatic begin_test(input string name);
        test_name  = name;
        test_errs  = 0;
        prev_valid = 1'b0;
    endtask

    task automatic begin_frame();
        for (int i = 0; i < 65536; i++) begin
            seen[i] = 1'b0;
        end
        frame_writes = 0;
        page_valid   = 1'b0;
        frame_open   = 1'b1;
    endtask

    task automatic end_frame();
        if (prev_valid && page_cur === page_prev) begin
            note_error($sformatf("%s: buffer page did not toggle between frames", test_name));
        end
        page_prev  = page_cur;
        prev_valid = 1'b1;
        frame_open = 1'b0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", test_name, test_errs);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    task automatic report();
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
    endtask

    initial begin
        tests_run    = 0;
        tests_failed = 0;
        frame_open   = 1'b0;
        frame_writes = 0;
    end

    always @(posedge i_clk) begin : compare
        int         x;
        int         y;
        logic [7:0] exp;
        if (i_rstn && i_vbuf_we) begin
            x = int'(i_vbuf_addr[7:0]);
            y = int'(i_vbuf_addr[15:8]);
            if (!frame_open) begin
                note_error($sformatf("%s: write to (%0d,%0d) outside a frame", test_name, x, y));
            end else begin
                exp = ref_pixel(x, y, i_ppuctrl, i_ppumask, i_scroll_x, i_scroll_y);
                if (exp !== i_vbuf_wdata) begin
                    note_error($sformatf("[FAIL] %s: pixel (%0d,%0d) expected %02h actual %02h",
                                         test_name, x, y, exp, i_vbuf_wdata));
                end
                if (seen[i_vbuf_addr[15:0]]) begin
                    note_error($sformatf("%s: pixel (%0d,%0d) written twice", test_name, x, y));
                end
                seen[i_vbuf_addr[15:0]] = 1'b1;
                if (!page_valid) begin
                    page_cur   = i_vbuf_addr[16];
                    page_valid = 1'b1;
                end else if (i_vbuf_addr[16] !== page_cur) begin
                    note_error($sformatf("%s: page changed inside a frame", test_name));
                end
                frame_writes++;
                if (frame_writes == FRAME_PIX) begin
                    frame_open = 1'b0;   // later writes are stray
                end
            end
        end
    end

endmodule

// ==== sim/tb_ppu_bg.sv ====
module tb_ppu_bg;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_CYC = 262 * 272;

    logic        clk;
    logic        rstn;
    logic [5:0]  ppuctrl;
    logic [7:0]  ppumask;
    logic [7:0]  scroll_x;
    logic [7:0]  scroll_y;
    logic        vblank;
    logic [11:0] pt_addr;
    logic [15:0] pt_rdata;
    logic [11:0] nt_addr;
    logic [7:0]  nt_rdata;
    logic [4:0]  plt_addr;
    logic [7:0]  plt_rdata;
    logic [16:0] vbuf_addr;
    logic        vbuf_we;
    logic [7:0]  vbuf_wdata;
    int unsigned seed_val;

    tb_clk_gen u_clk_gen (.o_clk(clk), .o_rstn(rstn));

    ppu_bg_render #(.SCAN_X_MAX(9'd271)) i_ppu_bg_render (
        .i_clk(clk), .i_rstn(rstn), .i_ppuctrl(ppuctrl), .i_ppumask(ppumask),
        .i_scroll_x(scroll_x), .i_scroll_y(scroll_y), .i_vblank(vblank),
        .o_pt_addr(pt_addr), .i_pt_rdata(pt_rdata), .o_nt_addr(nt_addr),
        .i_nt_rdata(nt_rdata), .o_plt_addr(plt_addr), .i_plt_rdata(plt_rdata),
        .o_vbuf_addr(vbuf_addr), .o_vbuf_we(vbuf_we), .o_vbuf_wdata(vbuf_wdata)
    );

    ppu_bg_checker u_checker (
        .i_clk(clk), .i_rstn(rstn), .i_vbuf_we(vbuf_we), .i_vbuf_addr(vbuf_addr),
        .i_vbuf_wdata(vbuf_wdata), .i_ppuctrl(ppuctrl), .i_ppumask(ppumask),
        .i_scroll_x(scroll_x), .i_scroll_y(scroll_y)
    );

    // synchronous read memories with one cycle of latency
    always @(posedge clk) begin
        nt_rdata  <= u_checker.nt_hash(nt_addr);
        pt_rdata  <= u_checker.pt_hash(pt_addr);
        plt_rdata <= u_checker.plt_byte(plt_addr);
    end

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("Verification failed");
        $finish;
    endtask

    task automatic render_frame(input logic [5:0] ctrl, input logic [7:0] mask,
                                input logic [7:0] sx, input logic [7:0] sy);
        int cnt;
        @(posedge clk);
        ppuctrl  <= ctrl;
        ppumask  <= mask;
        scroll_x <= sx;
        scroll_y <= sy;
        u_checker.begin_frame();
        @(posedge clk);
        vblank <= 1'b1;
        repeat (4) @(posedge clk);
        vblank <= 1'b0;
        cnt = 0;
        while (u_checker.frame_writes < u_checker.FRAME_PIX && u_checker.frame_open) begin
            @(posedge clk);
            cnt++;
            if (cnt > FRAME_CYC + 1000) begin
                abort_run("frame did not complete its buffer writes");
            end
        end
        repeat (400) @(posedge clk);   // idle gap before next vblank
        u_checker.end_frame();
    endtask

    function automatic logic [7:0] rand_fine(input logic [7:0] v, input int mod);
        logic [7:0] r;
        r = 8'(int'(v) % mod);
        if (r[2:0] == 3'd0) begin
            r[2:0] = 3'd5;             // keep fine scroll nonzero
        end
        return r;
    endfunction

    initial begin
        int cnt;
        ppuctrl  = '0;
        ppumask  = '0;
        scroll_x = '0;
        scroll_y = '0;
        vblank   = 1'b0;
        seed_val = $urandom(32'ha17a);
        cnt = 0;
        while (!rstn) begin
            @(posedge clk);
            cnt++;
            if (cnt > 100) begin
                abort_run("reset never released");
            end
        end

        u_checker.begin_test("zero_scroll");
        render_frame(6'h00, 8'h0a, 8'd0, 8'd0);
        u_checker.end_test();

        u_checker.begin_test("random_scroll");
        for (int f = 0; f < 3; f++) begin
            render_frame(6'($urandom % 4) | 6'(($urandom % 2) << 4), 8'h0a,
                         rand_fine(8'($urandom), 256), rand_fine(8'($urandom), 240));
        end
        u_checker.end_test();

        u_checker.begin_test("left_clip");
        render_frame(6'h01, 8'h08, 8'd37, 8'd101);
        u_checker.end_test();

        u_checker.begin_test("bg_disabled");
        render_frame(6'h02, 8'h02, 8'd90, 8'd17);
        u_checker.end_test();

        u_checker.begin_test("page_toggle");
        render_frame(6'h00, 8'h0a, 8'd3, 8'd9);
        render_frame(6'h00, 8'h0a, 8'd3, 8'd9);
        u_checker.end_test();

        u_checker.begin_test("base3_ptsel1");
        render_frame(6'h13, 8'h0a, 8'h4d, 8'hc3);
        u_checker.end_test();

        u_checker.report();
        if (u_checker.tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
common/ppu_pkg.sv
common/scan_if.sv
src/ppu_frame_ctrl.sv
src/ppu_scan_counter.sv
bg/ppu_bg_fetch.sv
bg/ppu_bg_shifter.sv
src/ppu_vbuf_writer.sv
src/ppu_bg_render.sv
sim/tb_clk_gen.sv
sim/ppu_bg_checker.sv
sim/tb_ppu_bg.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_ppu_bg -f flist.f -o sim_ppu_bg
./obj_dir/sim_ppu_bg > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0
